//--- cache_golden.txt
# num cmd addr data_in | hit data_out evict evict_dirty evict_addr evict_data
# cmd 0 NONE 1 LOAD 2 STORE 3 LOAD_MISS 4 STORE_MISS, num and cmd decimal, rest hex
# empty cache after reset
01 1 00001008 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
02 2 00001008 a1a1a1a100000001 0 0000000000000000 0 0 00000000 0000000000000000
03 0 00001008 a1a1a1a100000001 0 0000000000000000 0 0 00000000 0000000000000000
04 1 00001008 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
05 1 deadbe50 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
# clean fill, hits, store on hit
06 3 00001008 a1a1a1a100000001 0 0000000000000000 0 0 00000000 0000000000000000
07 1 00001008 0000000000000000 1 a1a1a1a100000001 0 0 00000000 0000000000000000
08 1 0000100c 0000000000000000 1 a1a1a1a100000001 0 0 00000000 0000000000000000
09 2 00001008 b2b2b2b200000002 1 a1a1a1a100000001 0 0 00000000 0000000000000000
10 1 00001008 0000000000000000 1 b2b2b2b200000002 0 0 00000000 0000000000000000
# set 2, dirty fill and miss commands that hit
11 4 deadbe50 c3c3c3c300000003 0 0000000000000000 0 0 00000000 0000000000000000
12 3 deadbe54 d4d4d4d400000004 1 c3c3c3c300000003 0 0 00000000 0000000000000000
13 1 deadbe50 0000000000000000 1 c3c3c3c300000003 0 0 00000000 0000000000000000
14 4 deadbe50 e1e1e1e100000009 1 c3c3c3c300000003 0 0 00000000 0000000000000000
15 1 deadbe50 0000000000000000 1 e1e1e1e100000009 0 0 00000000 0000000000000000
# set 1 filled to four ways, then replacements
16 3 00001048 0123456789abcdef 0 0000000000000000 0 0 00000000 0000000000000000
17 3 00001088 fedcba9876543210 0 0000000000000000 0 0 00000000 0000000000000000
18 4 800000cf 5a5a5a5aa5a5a5a5 0 0000000000000000 0 0 00000000 0000000000000000
19 0 00001108 0f0f0f0ff0f0f0f0 0 0000000000000000 0 0 00000000 0000000000000000
20 1 00001108 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
21 3 0000110c 0f0f0f0ff0f0f0f0 0 0000000000000000 1 1 00001008 b2b2b2b200000002
22 1 00001108 0000000000000000 1 0f0f0f0ff0f0f0f0 0 0 00000000 0000000000000000
23 1 00001008 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
24 3 00001148 13579bdf2468ace0 0 0000000000000000 1 0 00001048 0123456789abcdef
# reorder use of ways 0 1 2, way 3 becomes the victim
25 1 00001108 0000000000000000 1 0f0f0f0ff0f0f0f0 0 0 00000000 0000000000000000
26 1 00001148 0000000000000000 1 13579bdf2468ace0 0 0 00000000 0000000000000000
27 1 00001088 0000000000000000 1 fedcba9876543210 0 0 00000000 0000000000000000
28 4 00001188 777788889999aaaa 0 0000000000000000 1 1 800000c8 5a5a5a5aa5a5a5a5
29 1 00001188 0000000000000000 1 777788889999aaaa 0 0 00000000 0000000000000000
30 1 800000c8 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
31 0 00001188 0000000000000000 0 0000000000000000 0 0 00000000 0000000000000000
32 3 00001008 a1a1a1a100000001 0 0000000000000000 1 0 00001108 0f0f0f0ff0f0f0f0
33 1 00001008 0000000000000000 1 a1a1a1a100000001 0 0 00000000 0000000000000000

//--- flist.f
cache_pkg.sv
cache_lookup_if.sv
cache_wr_if.sv
cache_array_store.sv
cache_way_select.sv
cache_lru_matrix.sv
cache_req_ctrl.sv
cache_mem_top.sv
tb_clk_gen.sv
tb_cache_mem.sv

//--- Bender.yml
package:
  name: cache_mem

sources:
  - cache_pkg.sv
  - cache_lookup_if.sv
  - cache_wr_if.sv
  - cache_array_store.sv
  - cache_way_select.sv
  - cache_lru_matrix.sv
  - cache_req_ctrl.sv
  - cache_mem_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_cache_mem.sv

//--- tb_cache_mem.sv
// Cache memory array testbench

`timescale 1ns/1ps

module tb_cache_mem;

    localparam int    CLK_PERIOD  = 20;
    localparam int    RST_TIMEOUT = 20;
    localparam int    MAX_LINES   = 500;
    localparam string GOLDEN_FILE = "cache_golden.txt";

    logic                   clk;
    logic                   rst;
    cache_pkg::cache_cmd_e  cmd;
    cache_pkg::addr_t       addr;
    cache_pkg::block_t      wdata;
    logic                   hit;
    cache_pkg::block_t      rdata;
    logic                   evict;
    logic                   evict_dirty;
    cache_pkg::addr_t       evict_addr;
    cache_pkg::block_t      evict_data;

    // Per test and overall tally
    int  n_pass;
    int  n_fail;
    bit  test_ok;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(4)) u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    cache_mem_top uut (
        .clk_i (clk), .rst_i (rst), .cmd_i (cmd), .addr_i (addr), .data_i (wdata),
        .hit_o (hit), .data_o (rdata), .evict_o (evict), .evict_dirty_o (evict_dirty),
        .evict_addr_o (evict_addr), .evict_data_o (evict_data)
    );

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_block(input string name, input cache_pkg::block_t exp,
                               input cache_pkg::block_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t exp,
                              input cache_pkg::addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    // Blank lines and lines starting with # carry no test
    function automatic bit is_data_line(input string text);
        for (int i = 0; i < text.len(); i++) begin
            if (text[i] == "#") begin
                return 1'b0;
            end
            if (text[i] != " " && text[i] != "\t" && text[i] != "\n" && text[i] != "\r") begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Counted in falling edges, gives up after RST_TIMEOUT
    task automatic wait_reset_release(output bit released);
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        released = (rst === 1'b0);
    endtask

    // ========================================
    // Golden replay
    // ========================================

    initial begin
        int                 fd;
        int                 fields;
        int                 n_lines;
        int                 num;
        int                 cmd_val;
        string              line;
        bit                 released;
        bit                 run_err;
        logic               exp_hit;
        logic               exp_evict;
        logic               exp_dirty;
        cache_pkg::addr_t   in_addr;
        cache_pkg::addr_t   exp_eaddr;
        cache_pkg::block_t  in_data;
        cache_pkg::block_t  exp_data;
        cache_pkg::block_t  exp_edata;

        cmd     = cache_pkg::CMD_NONE;
        addr    = '0;
        wdata   = '0;
        n_pass  = 0;
        n_fail  = 0;
        n_lines = 0;
        run_err = 1'b0;

        wait_reset_release(released);
        fd = $fopen(GOLDEN_FILE, "r");
        if (!released) begin
            $display("Reset was still asserted after %0d cycles", RST_TIMEOUT);
            run_err = 1'b1;
        end else if (fd == 0) begin
            $display("Could not open golden file %s", GOLDEN_FILE);
            run_err = 1'b1;
        end else begin
            while (!run_err && n_lines < MAX_LINES && $fgets(line, fd) > 0) begin
                n_lines++;
                if (is_data_line(line)) begin
                    fields = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h", num, cmd_val,
                                     in_addr, in_data, exp_hit, exp_data, exp_evict,
                                     exp_dirty, exp_eaddr, exp_edata);
                    if (fields != 10 || cmd_val < 0 || cmd_val > 4) begin
                        $display("Golden file line %0d is malformed", n_lines);
                        run_err = 1'b1;
                    end else begin
                        // New request on the falling edge
                        @(negedge clk);
                        cmd   = cache_pkg::cache_cmd_e'(cmd_val[2:0]);
                        addr  = in_addr;
                        wdata = in_data;
                        // Responses are combinational, sample 2 ns before the rising edge
                        #(CLK_PERIOD / 2 - 2);
                        test_ok = 1'b1;
                        check_bit("hit_o", exp_hit, hit);
                        check_block("data_o", exp_data, rdata);
                        check_bit("evict_o", exp_evict, evict);
                        check_bit("evict_dirty_o", exp_dirty, evict_dirty);
                        check_addr("evict_addr_o", exp_eaddr, evict_addr);
                        check_block("evict_data_o", exp_edata, evict_data);
                        if (test_ok) begin
                            n_pass++;
                            $display("Test %0d %s %h passed", num, cmd.name(), addr);
                        end else begin
                            n_fail++;
                            $display("Test %0d %s %h failed", num, cmd.name(), addr);
                        end
                    end
                end
            end
            $fclose(fd);
            if (n_lines >= MAX_LINES) begin
                $display("Golden file is longer than %0d lines", MAX_LINES);
                run_err = 1'b1;
            end else if (n_pass + n_fail == 0) begin
                $display("Golden file %s holds no tests", GOLDEN_FILE);
                run_err = 1'b1;
            end
        end

        $display("Tests passed %0d, failed %0d", n_pass, n_fail);
        if (!run_err && n_fail == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    // Free running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Reset held for whole cycles, dropped just after a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- cache_mem_top.sv
// Cache memory array top level

`timescale 1ns/1ps

module cache_mem_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  cache_pkg::cache_cmd_e  cmd_i,
    input  cache_pkg::addr_t       addr_i,
    input  cache_pkg::block_t      data_i,
    output logic                   hit_o,
    output cache_pkg::block_t      data_o,
    output logic                   evict_o,
    output logic                   evict_dirty_o,
    output cache_pkg::addr_t       evict_addr_o,
    output cache_pkg::block_t      evict_data_o
);

    cache_pkg::tag_t      req_tag;
    cache_pkg::idx_t      req_idx;
    logic                 hit;
    cache_pkg::way_t      hit_way;
    logic                 empty;
    cache_pkg::way_t      empty_way;
    cache_pkg::way_t      victim_way;
    cache_pkg::way_vec_t  access;

    // Tag above index, byte offset dropped
    assign req_tag = addr_i[cache_pkg::XLEN-1 -: cache_pkg::TAG_W];
    assign req_idx = addr_i[cache_pkg::OFFSET_W +: cache_pkg::IDX_W];

    cache_lookup_if lookup_bus ();
    cache_wr_if     wr_bus ();

    // ========================================
    // Datapath
    // ========================================

    cache_array_store u_store (
        .clk_i (clk_i), .rst_i (rst_i), .idx_i (req_idx),
        .lookup (lookup_bus.source), .wr (wr_bus.sink)
    );

    cache_way_select u_select (
        .tag_i (req_tag), .lookup (lookup_bus.sink),
        .hit_o (hit), .hit_way_o (hit_way),
        .empty_o (empty), .empty_way_o (empty_way)
    );

    cache_lru_matrix u_lru (
        .clk_i (clk_i), .rst_i (rst_i), .idx_i (req_idx),
        .access_i (access), .victim_way_o (victim_way)
    );

    cache_req_ctrl u_ctrl (
        .cmd_i (cmd_i), .tag_i (req_tag), .idx_i (req_idx), .data_i (data_i),
        .lookup (lookup_bus.sink), .hit_i (hit), .hit_way_i (hit_way),
        .empty_i (empty), .empty_way_i (empty_way), .victim_way_i (victim_way),
        .wr (wr_bus.source), .access_o (access),
        .hit_o (hit_o), .data_o (data_o),
        .evict_o (evict_o), .evict_dirty_o (evict_dirty_o),
        .evict_addr_o (evict_addr_o), .evict_data_o (evict_data_o)
    );

endmodule

//--- cache_req_ctrl.sv
// Cache request decoder

`timescale 1ns/1ps

module cache_req_ctrl (
    input  cache_pkg::cache_cmd_e  cmd_i,
    input  cache_pkg::tag_t        tag_i,
    input  cache_pkg::idx_t        idx_i,
    input  cache_pkg::block_t      data_i,
    cache_lookup_if.sink           lookup,
    input  logic                   hit_i,
    input  cache_pkg::way_t        hit_way_i,
    input  logic                   empty_i,
    input  cache_pkg::way_t        empty_way_i,
    input  cache_pkg::way_t        victim_way_i,
    cache_wr_if.source             wr,
    output cache_pkg::way_vec_t    access_o,
    output logic                   hit_o,
    output cache_pkg::block_t      data_o,
    output logic                   evict_o,
    output logic                   evict_dirty_o,
    output cache_pkg::addr_t       evict_addr_o,
    output cache_pkg::block_t      evict_data_o
);

    logic             fill;
    logic             acc_en;
    cache_pkg::way_t  acc_way;
    cache_pkg::way_t  fill_way;

    // Empty way first, else the LRU victim
    assign fill_way = empty_i ? empty_way_i : victim_way_i;

    // ========================================
    // Command decode
    // ========================================

    always_comb begin
        hit_o       = 1'b0;
        fill        = 1'b0;
        acc_en      = 1'b0;
        acc_way     = hit_way_i;
        wr.wr_en    = 1'b0;
        wr.wr_way   = hit_way_i;
        wr.wr_dirty = 1'b1;
        case (cmd_i)
            cache_pkg::CMD_LOAD: begin
                hit_o  = hit_i;
                acc_en = hit_i;
            end
            cache_pkg::CMD_STORE: begin
                hit_o    = hit_i;
                acc_en   = hit_i;
                wr.wr_en = hit_i;
            end
            // Present block is only read
            cache_pkg::CMD_LOAD_MISS: begin
                hit_o  = hit_i;
                acc_en = 1'b1;
                if (!hit_i) begin
                    fill        = 1'b1;
                    wr.wr_en    = 1'b1;
                    wr.wr_way   = fill_way;
                    wr.wr_dirty = 1'b0;
                    acc_way     = fill_way;
                end
            end
            // Present block is overwritten like a store
            cache_pkg::CMD_STORE_MISS: begin
                hit_o    = hit_i;
                acc_en   = 1'b1;
                wr.wr_en = 1'b1;
                if (!hit_i) begin
                    fill      = 1'b1;
                    wr.wr_way = fill_way;
                    acc_way   = fill_way;
                end
            end
            default: begin
            end
        endcase
    end

    // Remaining write fields follow the request
    assign wr.wr_idx   = idx_i;
    assign wr.wr_valid = 1'b1;
    assign wr.wr_tag   = tag_i;
    assign wr.wr_block = data_i;

    // Touched way becomes most recent
    assign access_o = acc_en ? (cache_pkg::way_vec_t'(1'b1) << acc_way) : '0;

    // Old block on any hit
    assign data_o = hit_o ? lookup.blocks[hit_way_i] : '0;

    // ========================================
    // Eviction report
    // ========================================

    // Fill into a full set replaces the victim
    assign evict_o       = fill & ~empty_i;
    assign evict_dirty_o = evict_o & lookup.dirty[victim_way_i];
    assign evict_addr_o  = evict_o ?
        {lookup.tags[victim_way_i], idx_i, {cache_pkg::OFFSET_W{1'b0}}} : '0;
    assign evict_data_o  = evict_o ? lookup.blocks[victim_way_i] : '0;

endmodule

//--- cache_lru_matrix.sv
// Per-set LRU pair matrix

`timescale 1ns/1ps

module cache_lru_matrix (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  cache_pkg::idx_t       idx_i,
    input  cache_pkg::way_vec_t   access_i,
    output cache_pkg::way_t       victim_way_o
);

    // Pair bits of every set
    cache_pkg::hist_t [cache_pkg::NUM_SETS-1:0]  hist_q;
    cache_pkg::hist_t                            hist_cur;
    cache_pkg::hist_t                            hist_next;

    // Bit position of pair (lo, hi) with lo < hi
    // Pairs are packed row by row, (0,1) (0,2) (0,3) (1,2) ...
    function automatic int pair_idx(input int lo, input int hi);
        return lo * cache_pkg::NUM_WAYS - (lo * (lo + 1)) / 2 + (hi - lo - 1);
    endfunction

    assign hist_cur = hist_q[idx_i];

    // ========================================
    // Update on access
    // ========================================

    // Set bit when the higher way of the pair is accessed
    // Clear it when the lower way is accessed
    always_comb begin
        hist_next = hist_cur;
        for (int lo = 0; lo < cache_pkg::NUM_WAYS - 1; lo++) begin
            for (int hi = lo + 1; hi < cache_pkg::NUM_WAYS; hi++) begin
                if (access_i[hi]) begin
                    hist_next[pair_idx(lo, hi)] = 1'b1;
                end else if (access_i[lo]) begin
                    hist_next[pair_idx(lo, hi)] = 1'b0;
                end
            end
        end
    end

    // Only the addressed set moves
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hist_q <= '0;
        end else if (|access_i) begin
            hist_q[idx_i] <= hist_next;
        end
    end

    // ========================================
    // Victim
    // ========================================

    // Way older than every other way of the set
    // A cleared matrix ranks ways by number, highest way oldest
    always_comb begin
        logic oldest;
        victim_way_o = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            oldest = 1'b1;
            for (int k = 0; k < cache_pkg::NUM_WAYS; k++) begin
                if (k < w) begin
                    oldest &= ~hist_cur[pair_idx(k, w)];
                end else if (k > w) begin
                    oldest &= hist_cur[pair_idx(w, k)];
                end
            end
            if (oldest) begin
                victim_way_o = cache_pkg::way_t'(w);
            end
        end
    end

endmodule

//--- cache_way_select.sv
// Hit and empty way selection

`timescale 1ns/1ps

module cache_way_select (
    input  cache_pkg::tag_t   tag_i,
    cache_lookup_if.sink      lookup,
    output logic              hit_o,
    output cache_pkg::way_t   hit_way_o,
    output logic              empty_o,
    output cache_pkg::way_t   empty_way_o
);

    // Tag compare over the valid ways of the set
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (lookup.valid[w] && (lookup.tags[w] == tag_i)) begin
                hit_o     = 1'b1;
                hit_way_o = cache_pkg::way_t'(w);
            end
        end
    end

    // Lowest invalid way
    // Scan downwards so the lowest index is written last
    always_comb begin
        empty_o     = 1'b0;
        empty_way_o = '0;
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!lookup.valid[w]) begin
                empty_o     = 1'b1;
                empty_way_o = cache_pkg::way_t'(w);
            end
        end
    end

endmodule

//--- cache_array_store.sv
// Cache state arrays

`timescale 1ns/1ps

module cache_array_store (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  cache_pkg::idx_t       idx_i,
    cache_lookup_if.source        lookup,
    cache_wr_if.sink              wr
);

    // ========================================
    // Storage
    // ========================================

    // Control bits, one vector per set
    cache_pkg::way_vec_t [cache_pkg::NUM_SETS-1:0]  valid_q;
    cache_pkg::way_vec_t [cache_pkg::NUM_SETS-1:0]  dirty_q;

    // Tag and data rows, one packed row per set
    cache_pkg::tag_t   [cache_pkg::NUM_WAYS-1:0]    tag_q   [cache_pkg::NUM_SETS];
    cache_pkg::block_t [cache_pkg::NUM_WAYS-1:0]    block_q [cache_pkg::NUM_SETS];

    // Valid and dirty cleared on reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr.wr_en) begin
            valid_q[wr.wr_idx][wr.wr_way] <= wr.wr_valid;
            dirty_q[wr.wr_idx][wr.wr_way] <= wr.wr_dirty;
        end
    end

    // Tag and payload, only meaningful once valid
    always_ff @(posedge clk_i) begin
        if (wr.wr_en) begin
            tag_q[wr.wr_idx][wr.wr_way]   <= wr.wr_tag;
            block_q[wr.wr_idx][wr.wr_way] <= wr.wr_block;
        end
    end

    // ========================================
    // Read side
    // ========================================

    // Current contents of the addressed set
    assign lookup.valid  = valid_q[idx_i];
    assign lookup.dirty  = dirty_q[idx_i];
    assign lookup.tags   = tag_q[idx_i];
    assign lookup.blocks = block_q[idx_i];

endmodule

//--- cache_wr_if.sv
// Single way write bus

`timescale 1ns/1ps

interface cache_wr_if;

    // Strobe, one way per rising edge
    logic                wr_en;
    cache_pkg::idx_t     wr_idx;
    cache_pkg::way_t     wr_way;
    // New way state
    logic                wr_valid;
    logic                wr_dirty;
    cache_pkg::tag_t     wr_tag;
    cache_pkg::block_t   wr_block;

    // Request controller side
    modport source (
        output wr_en, wr_idx, wr_way, wr_valid, wr_dirty, wr_tag, wr_block
    );

    // Storage side
    modport sink (
        input wr_en, wr_idx, wr_way, wr_valid, wr_dirty, wr_tag, wr_block
    );

endinterface

//--- cache_lookup_if.sv
// Addressed set lookup bus

`timescale 1ns/1ps

interface cache_lookup_if;

    // Per-way state of the set picked by the index
    cache_pkg::way_vec_t                          valid;
    cache_pkg::way_vec_t                          dirty;
    // Packed per way, element n is way n
    cache_pkg::tag_t   [cache_pkg::NUM_WAYS-1:0]  tags;
    cache_pkg::block_t [cache_pkg::NUM_WAYS-1:0]  blocks;

    // Storage side
    modport source (
        output valid, dirty, tags, blocks
    );

    // Selector and controller side
    modport sink (
        input valid, dirty, tags, blocks
    );

endinterface

//--- cache_pkg.sv
// Cache shared definitions

package cache_pkg;

    // ========================================
    // Geometry
    // ========================================

    // Byte address width
    localparam int XLEN       = 32;
    // One block per way
    localparam int BLOCK_BITS = 64;
    localparam int NUM_SETS   = 8;
    localparam int NUM_WAYS   = 4;

    // Address split, offset ignored on lookup
    localparam int OFFSET_W   = $clog2(BLOCK_BITS / 8);
    localparam int IDX_W      = $clog2(NUM_SETS);
    localparam int TAG_W      = XLEN - IDX_W - OFFSET_W;
    localparam int WAY_W      = $clog2(NUM_WAYS);

    // One bit per unordered pair of ways
    localparam int HIST_W     = (NUM_WAYS * (NUM_WAYS - 1)) / 2;

    // ========================================
    // Vector types
    // ========================================

    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [IDX_W-1:0]      idx_t;
    typedef logic [WAY_W-1:0]      way_t;
    // One bit per way, bit n is way n
    typedef logic [NUM_WAYS-1:0]   way_vec_t;
    typedef logic [BLOCK_BITS-1:0] block_t;
    // Pair matrix of one set
    typedef logic [HIST_W-1:0]     hist_t;

    // Request commands
    typedef enum logic [2:0] {
        CMD_NONE       = 3'd0,
        CMD_LOAD       = 3'd1,
        CMD_STORE      = 3'd2,
        CMD_LOAD_MISS  = 3'd3,
        CMD_STORE_MISS = 3'd4
    } cache_cmd_e;

endpackage
